// ==== include/boxcar_defs.svh ====
`ifndef BOXCAR_DEFS_SVH
`define BOXCAR_DEFS_SVH

// Sample and average width
`define SAMPLE_W      16
// Window length and its log2, which sets the average shift and the sum growth
`define TAPS          16
`define TAPS_LOG2     4
// Decimation period field and overrun counter
`define DECIM_W       16
`define CNT_W         16
`define DECIM_RESET   16'd3

// AXI4-Lite bus widths
`define AXIL_ADDR_W   4
`define AXIL_DATA_W   32
`define AXIL_RESP_OKAY 2'b00

// Register offsets
`define REG_CTRL      4'h0
`define REG_DECIM     4'h4
`define REG_STATUS    4'h8
`define REG_LAST      4'hC

`endif

// ==== logic/boxcar_pkg.sv ====
`include "boxcar_defs.svh"

package boxcar_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Stream beats
    ////////////////////////////////////////////////////////////////////////////

    // Input sample as seen on the accept strobe
    typedef struct packed {
        logic                        valid;
        logic signed [`SAMPLE_W-1:0] data;
    } sample_beat_t;

    // Window average leaving the accumulator
    typedef struct packed {
        logic                        valid;
        logic signed [`SAMPLE_W-1:0] data;
    } avg_beat_t;

    ////////////////////////////////////////////////////////////////////////////
    // Control and status
    ////////////////////////////////////////////////////////////////////////////

    // Flush is a one-cycle pulse
    typedef struct packed {
        logic                enable;
        logic                flush;
        logic [`DECIM_W-1:0] decim;
    } boxcar_cfg_t;

    typedef struct packed {
        logic [`CNT_W-1:0]           overrun_cnt;
        logic signed [`SAMPLE_W-1:0] last_avg;
    } boxcar_status_t;

    ////////////////////////////////////////////////////////////////////////////
    // AXI4-Lite
    ////////////////////////////////////////////////////////////////////////////

    // Master-driven side
    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0]   awaddr;
        logic                      awvalid;
        logic [`AXIL_DATA_W-1:0]   wdata;
        logic [`AXIL_DATA_W/8-1:0] wstrb;
        logic                      wvalid;
        logic                      bready;
        logic [`AXIL_ADDR_W-1:0]   araddr;
        logic                      arvalid;
        logic                      rready;
    } axil_req_t;

    // Slave-driven side
    typedef struct packed {
        logic                    awready;
        logic                    wready;
        logic                    bvalid;
        logic [1:0]              bresp;
        logic                    arready;
        logic                    rvalid;
        logic [`AXIL_DATA_W-1:0] rdata;
        logic [1:0]              rresp;
    } axil_rsp_t;

endpackage

// ==== logic/rate_strobe_gen.sv ====
`timescale 1ns/100ps
`include "boxcar_defs.svh"

module rate_strobe_gen
(
    input  logic                    a_clk,
    input  logic                    reset,
    input  boxcar_pkg::boxcar_cfg_t cfg,
    output logic                    strobe
);

    // Clocks left until the next accept
    logic [`DECIM_W-1:0] count;

    ////////////////////////////////////////////////////////////////////////////
    // Down-counter, one strobe every decim+1 clocks
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        // Idle, flushed or in reset: park at full period
        if (reset || cfg.flush || !cfg.enable)
        begin
            count  <= cfg.decim;
            strobe <= 1'b0;
        end
        else if (count == '0)
        begin
            // Terminal count, fire and reload
            count  <= cfg.decim;
            strobe <= 1'b1;
        end
        else
        begin
            count  <= count - 1'b1;
            strobe <= 1'b0;
        end
    end

    // Period 0 keeps count at zero, so the strobe stays high every clock

endmodule

// ==== logic/boxcar_accumulator.sv ====
`timescale 1ns/100ps
`include "boxcar_defs.svh"

module boxcar_accumulator
(
    input  logic                     a_clk,
    input  logic                     reset,
    input  logic                     strobe,
    input  boxcar_pkg::boxcar_cfg_t  cfg,
    input  boxcar_pkg::sample_beat_t sample,
    output boxcar_pkg::avg_beat_t    avg
);

    // Sum grows by log2 of the window length
    localparam int SUM_W = `SAMPLE_W + `TAPS_LOG2;

    // Window memory and write pointer
    logic signed [`SAMPLE_W-1:0]  window [`TAPS];
    logic        [`TAPS_LOG2-1:0] wr_idx;

    // Captured sample and its update flag
    logic signed [`SAMPLE_W-1:0]  data_in;
    logic                         run;

    // Running sum and output valid
    logic signed [SUM_W-1:0]      sum;
    logic                         avg_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1, capture on the accept strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        // Flush drops a sample in flight
        if (reset || cfg.flush)
            run <= 1'b0;
        else
            run <= strobe;
    end

    always_ff @(posedge a_clk)
    begin
        if (strobe)
        begin
            // Missing sample counts as zero
            if (sample.valid)
                data_in <= sample.data;
            else
                data_in <= '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2, replace oldest entry and adjust sum
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (reset || cfg.flush)
        begin
            for (int k = 0; k < `TAPS; k++)
                window[k] <= '0;
            wr_idx    <= '0;
            sum       <= '0;
            avg_valid <= 1'b0;
        end
        else
        begin
            avg_valid <= run;
            if (run)
            begin
                // New minus old, sign extended to the sum width
                sum            <= sum - window[wr_idx] + data_in;
                window[wr_idx] <= data_in;
                // Wraps at the window length
                wr_idx         <= wr_idx + 1'b1;
            end
        end
    end

    // Upper slice of the sum is the arithmetic shift by TAPS_LOG2
    always_comb
    begin
        avg.valid = avg_valid;
        avg.data  = sum[SUM_W-1:`TAPS_LOG2];
    end

endmodule

// ==== logic/result_port.sv ====
`timescale 1ns/100ps
`include "boxcar_defs.svh"

module result_port
(
    input  logic                          a_clk,
    input  logic                          reset,
    input  boxcar_pkg::avg_beat_t         avg,
    input  logic                          m_tready,
    input  logic                          clear_overrun,
    output logic signed [`SAMPLE_W-1:0]   m_tdata,
    output logic                          m_tvalid,
    output boxcar_pkg::boxcar_status_t    status
);

    // Held beat not taken this cycle
    logic stalled;

    assign stalled = m_tvalid && !m_tready;

    ////////////////////////////////////////////////////////////////////////////
    // One-entry holding register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (reset)
            m_tvalid <= 1'b0;
        else if (avg.valid)
            m_tvalid <= 1'b1;
        else if (m_tready)
            m_tvalid <= 1'b0;
    end

    // Newest beat always wins the register
    always_ff @(posedge a_clk)
    begin
        if (avg.valid)
            m_tdata <= avg.data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Overrun count and last average
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (reset)
        begin
            status.overrun_cnt <= '0;
            status.last_avg    <= '0;
        end
        else
        begin
            // Clear from the register block beats a same-cycle overrun
            if (clear_overrun)
                status.overrun_cnt <= '0;
            else if (avg.valid && stalled && (status.overrun_cnt != '1))
                status.overrun_cnt <= status.overrun_cnt + 1'b1;

            // Readback copy, taken on every beat
            if (avg.valid)
                status.last_avg <= avg.data;
        end
    end

endmodule

// ==== logic/boxcar_regs.sv ====
`timescale 1ns/100ps
`include "boxcar_defs.svh"

module boxcar_regs
(
    input  logic                       a_clk,
    input  logic                       reset,
    input  boxcar_pkg::axil_req_t      axil_req,
    input  boxcar_pkg::boxcar_status_t status,
    output boxcar_pkg::axil_rsp_t      axil_rsp,
    output boxcar_pkg::boxcar_cfg_t    cfg,
    output logic                       clear_overrun
);

    // Control registers
    logic                    enable_q;
    logic                    flush_q;
    logic [`DECIM_W-1:0]     decim_q;
    logic                    clear_q;

    // Channel state, awready doubles as wready
    logic                    awready_q;
    logic                    bvalid_q;
    logic                    arready_q;
    logic                    rvalid_q;
    logic [`AXIL_DATA_W-1:0] rdata_q;
    logic [`AXIL_DATA_W-1:0] rd_mux;

    // Handshake cycles
    logic                    wr_fire;
    logic                    rd_fire;

    assign wr_fire = awready_q && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire = arready_q && axil_req.arvalid;

    ////////////////////////////////////////////////////////////////////////////
    // Write address, data and response
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (reset)
        begin
            awready_q <= 1'b0;
            bvalid_q  <= 1'b0;
        end
        else
        begin
            // Ready for one cycle once both halves are present
            awready_q <= axil_req.awvalid && axil_req.wvalid && !awready_q && !bvalid_q;
            if (wr_fire)
                bvalid_q <= 1'b1;
            else if (bvalid_q && axil_req.bready)
                bvalid_q <= 1'b0;
        end
    end

    // Register file update on the write handshake
    always_ff @(posedge a_clk)
    begin
        if (reset)
        begin
            enable_q <= 1'b0;
            flush_q  <= 1'b0;
            clear_q  <= 1'b0;
            decim_q  <= `DECIM_RESET;
        end
        else
        begin
            // Pulses last one clock
            flush_q <= 1'b0;
            clear_q <= 1'b0;
            if (wr_fire)
            begin
                case (axil_req.awaddr)
                    `REG_CTRL:
                    begin
                        if (axil_req.wstrb[0])
                        begin
                            enable_q <= axil_req.wdata[0];
                            flush_q  <= axil_req.wdata[1];
                        end
                    end
                    `REG_DECIM:
                    begin
                        if (axil_req.wstrb[0])
                            decim_q[7:0] <= axil_req.wdata[7:0];
                        if (axil_req.wstrb[1])
                            decim_q[15:8] <= axil_req.wdata[15:8];
                    end
                    // Any write clears the overrun count
                    `REG_STATUS: clear_q <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read address and data
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (reset)
        begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end
        else
        begin
            arready_q <= axil_req.arvalid && !arready_q && !rvalid_q;
            if (rd_fire)
                rvalid_q <= 1'b1;
            else if (rvalid_q && axil_req.rready)
                rvalid_q <= 1'b0;
        end
    end

    // Read mux, flush always reads back 0
    always_comb
    begin
        rd_mux = '0;
        case (axil_req.araddr)
            `REG_CTRL:   rd_mux[0] = enable_q;
            `REG_DECIM:  rd_mux[`DECIM_W-1:0] = decim_q;
            `REG_STATUS: rd_mux[`CNT_W-1:0] = status.overrun_cnt;
            // Sign extended average
            `REG_LAST:   rd_mux = {{(`AXIL_DATA_W-`SAMPLE_W){status.last_avg[`SAMPLE_W-1]}},
                                   status.last_avg};
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge a_clk)
    begin
        if (rd_fire)
            rdata_q <= rd_mux;
    end

    // Bus and control outputs
    always_comb
    begin
        axil_rsp.awready = awready_q;
        axil_rsp.wready  = awready_q;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = `AXIL_RESP_OKAY;
        axil_rsp.arready = arready_q;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = `AXIL_RESP_OKAY;
        cfg.enable       = enable_q;
        cfg.flush        = flush_q;
        cfg.decim        = decim_q;
        clear_overrun    = clear_q;
    end

endmodule

// ==== logic/boxcar_top.sv ====
`timescale 1ns/100ps
`include "boxcar_defs.svh"

module boxcar_top
(
    input  logic                        a_clk,
    input  logic                        reset,
    input  boxcar_pkg::axil_req_t       axil_req,
    output boxcar_pkg::axil_rsp_t       axil_rsp,
    input  logic signed [`SAMPLE_W-1:0] s_tdata,
    input  logic                        s_tvalid,
    output logic                        s_tready,
    output logic signed [`SAMPLE_W-1:0] m_tdata,
    output logic                        m_tvalid,
    input  logic                        m_tready
);

    // Control and status between register block and datapath
    boxcar_pkg::boxcar_cfg_t    cfg;
    boxcar_pkg::boxcar_status_t status;
    logic                       clear_overrun;

    // Sample path
    logic                       strobe;
    boxcar_pkg::sample_beat_t   sample;
    boxcar_pkg::avg_beat_t      avg;

    // Accept happens only on the strobe
    assign s_tready = strobe;

    always_comb
    begin
        sample.valid = s_tvalid;
        sample.data  = s_tdata;
    end

    boxcar_regs i_regs
    (
        .a_clk         (a_clk),
        .reset         (reset),
        .axil_req      (axil_req),
        .status        (status),
        .axil_rsp      (axil_rsp),
        .cfg           (cfg),
        .clear_overrun (clear_overrun)
    );

    rate_strobe_gen i_strobe
    (
        .a_clk  (a_clk),
        .reset  (reset),
        .cfg    (cfg),
        .strobe (strobe)
    );

    boxcar_accumulator i_accum
    (
        .a_clk  (a_clk),
        .reset  (reset),
        .strobe (strobe),
        .cfg    (cfg),
        .sample (sample),
        .avg    (avg)
    );

    result_port i_result
    (
        .a_clk         (a_clk),
        .reset         (reset),
        .avg           (avg),
        .m_tready      (m_tready),
        .clear_overrun (clear_overrun),
        .m_tdata       (m_tdata),
        .m_tvalid      (m_tvalid),
        .status        (status)
    );

endmodule

// ==== tests/boxcar_tb.sv ====
`timescale 1ns/100ps
`include "boxcar_defs.svh"

module boxcar_tb;

    // Wait limits in clocks
    localparam int AXI_LIMIT    = 32;
    localparam int STREAM_LIMIT = 4000;
    // Accept strobe to m_tvalid
    localparam int LATENCY      = 3;

    logic                        a_clk;
    logic                        reset;
    boxcar_pkg::axil_req_t       axil_req;
    boxcar_pkg::axil_rsp_t       axil_rsp;
    logic signed [`SAMPLE_W-1:0] s_tdata;
    logic                        s_tvalid;
    logic                        s_tready;
    logic signed [`SAMPLE_W-1:0] m_tdata;
    logic                        m_tvalid;
    logic                        m_tready;

    int seed = 32'h3d97ba8b;

    // Reference window and averages still due at the output
    logic signed [`SAMPLE_W-1:0] model_win [$];
    logic signed [`SAMPLE_W-1:0] exp_q [$];

    // Stream bookkeeping kept by the monitor
    int                          accepted;
    int                          delivered;
    logic signed [`SAMPLE_W-1:0] last_sample;
    logic signed [`SAMPLE_W-1:0] last_out;
    int                          cycle;
    logic                        mv_prev;
    logic                        record_timing;
    int                          strobe_at [$];
    int                          rise_at [$];

    // Test bookkeeping
    string test_name;
    int    tests_run;
    int    checks;
    int    errors;
    int    errors_at_start;

    // Random choices, all drawn at time 0
    int d_readback;
    int d_period;
    int d_avg;
    int d_overrun;
    int n_target;

    initial
        a_clk = 1'b0;

    always #20 a_clk = ~a_clk;

    boxcar_top i_dut
    (
        .a_clk    (a_clk),
        .reset    (reset),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready)
    );

    // Random samples, valid roughly three clocks in four
    always @(posedge a_clk)
    begin
        s_tdata  <= $random(seed);
        s_tvalid <= ($random(seed) & 3) != 0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks and reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic expect_equal(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            $display("ERR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic confirm_done(input logic done, input string what);
        checks++;
        assert (done)
        else
        begin
            $display("%s: timed out waiting for %s", test_name, what);
            errors++;
        end
    endtask

    // Window of zeros, as after reset or flush
    task automatic clear_model();
        model_win.delete();
        repeat (`TAPS)
            model_win.push_back('0);
    endtask

    function automatic logic signed [`SAMPLE_W-1:0] model_avg();
        int acc;
        acc = 0;
        foreach (model_win[k])
            acc += model_win[k];
        // Arithmetic shift on the full-width sum
        acc = acc >>> `TAPS_LOG2;
        return acc[`SAMPLE_W-1:0];
    endfunction

    // Samples pre-edge values, the same ones the DUT sees
    always @(posedge a_clk)
    begin : monitor
        logic signed [`SAMPLE_W-1:0] smp;
        logic signed [`SAMPLE_W-1:0] want;
        if (!reset)
        begin
            // Missing sample enters the window as zero
            if (s_tready)
            begin
                smp = s_tvalid ? s_tdata : '0;
                // Oldest sample leaves the window
                model_win.delete(0);
                model_win.push_back(smp);
                exp_q.push_back(model_avg());
                last_sample = smp;
                accepted++;
                if (record_timing)
                    strobe_at.push_back(cycle);
            end
            if (m_tvalid && m_tready)
            begin
                checks++;
                assert (exp_q.size() > 0)
                else
                begin
                    $display("%s: result beat came out with no accepted sample behind it",
                             test_name);
                    errors++;
                end
                if (exp_q.size() > 0)
                begin
                    want = exp_q.pop_front();
                    expect_equal("average", want, m_tdata);
                end
                last_out = m_tdata;
                delivered++;
            end
            if (record_timing && m_tvalid && !mv_prev)
                rise_at.push_back(cycle);
            mv_prev = m_tvalid;
        end
        cycle++;
    end

    ////////////////////////////////////////////////////////////////////////////
    // AXI4-Lite master
    ////////////////////////////////////////////////////////////////////////////

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
        int n;
        @(posedge a_clk);
        axil_req.awaddr  <= addr;
        axil_req.awvalid <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hf;
        axil_req.wvalid  <= 1'b1;
        axil_req.bready  <= 1'b1;
        n = 0;
        do
        begin
            @(posedge a_clk);
            n++;
        end
        while (!axil_rsp.awready && n < AXI_LIMIT);
        confirm_done(axil_rsp.awready, "write address ready");
        // Both ready signals rise together
        expect_equal("wready", 1, axil_rsp.wready);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        n = 0;
        do
        begin
            @(posedge a_clk);
            n++;
        end
        while (!axil_rsp.bvalid && n < AXI_LIMIT);
        confirm_done(axil_rsp.bvalid, "write response");
        expect_equal("bresp", 0, axil_rsp.bresp);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
        int n;
        @(posedge a_clk);
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
        axil_req.rready  <= 1'b1;
        n = 0;
        do
        begin
            @(posedge a_clk);
            n++;
        end
        while (!axil_rsp.arready && n < AXI_LIMIT);
        confirm_done(axil_rsp.arready, "read address ready");
        axil_req.arvalid <= 1'b0;
        n = 0;
        do
        begin
            @(posedge a_clk);
            n++;
        end
        while (!axil_rsp.rvalid && n < AXI_LIMIT);
        confirm_done(axil_rsp.rvalid, "read data");
        expect_equal("rresp", 0, axil_rsp.rresp);
        data = axil_rsp.rdata;
        axil_req.rready <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stream waits, checked between edges
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_accepted(input int target);
        int n;
        n = 0;
        do
        begin
            @(negedge a_clk);
            n++;
        end
        while (accepted < target && n < STREAM_LIMIT);
        confirm_done(accepted >= target, "accepted samples");
    endtask

    task automatic await_beats(input int target);
        int n;
        n = 0;
        do
        begin
            @(negedge a_clk);
            n++;
        end
        while (delivered < target && n < STREAM_LIMIT);
        confirm_done(delivered >= target, "a result beat");
    endtask

    // Every expected average has left the port
    task automatic drain_results();
        int n;
        n = 0;
        do
        begin
            @(negedge a_clk);
            n++;
        end
        while (exp_q.size() != 0 && n < STREAM_LIMIT);
        confirm_done(exp_q.size() == 0, "the result stream to drain");
    endtask

    task automatic stop_and_drain();
        axil_write(`REG_CTRL, 32'h0);
        drain_results();
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == errors_at_start)
            $display("test %-16s ok", test_name);
        else
            $display("test %-16s failed with %0d errors", test_name, errors - errors_at_start);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [31:0]                 rd;
        logic signed [`SAMPLE_W-1:0] first;
        logic signed [`SAMPLE_W-1:0] newest;
        int                          acc0;
        int                          del0;
        int                          n_beats;
        int                          n;
        int                          i;

        axil_req      = '0;
        s_tdata       = '0;
        s_tvalid      = 1'b0;
        m_tready      = 1'b0;
        reset         = 1'b1;
        record_timing = 1'b0;
        mv_prev       = 1'b0;
        accepted      = 0;
        delivered     = 0;
        cycle         = 0;
        tests_run     = 0;
        checks        = 0;
        errors        = 0;
        clear_model();

        d_readback = $random(seed) & 7;
        d_period   = 1 + (($random(seed) & 32'h7fff_ffff) % 7);
        d_avg      = $random(seed) & 7;
        d_overrun  = 2 + (($random(seed) & 32'h7fff_ffff) % 6);
        n_target   = 5 + ($random(seed) & 3);

        repeat (16) @(posedge a_clk);
        reset <= 1'b0;

        // Reset values and DECIM readback
        start_test("reg_reset");
        axil_read(`REG_CTRL, rd);
        expect_equal("CTRL", 32'h0, rd);
        axil_read(`REG_DECIM, rd);
        expect_equal("DECIM", 32'd3, rd);
        axil_read(`REG_STATUS, rd);
        expect_equal("STATUS", 32'h0, rd);
        axil_read(`REG_LAST, rd);
        expect_equal("LAST", 32'h0, rd);
        axil_read(4'h2, rd);
        expect_equal("undefined offset", 32'h0, rd);
        repeat (50)
        begin
            @(negedge a_clk);
            expect_equal("m_tvalid while disabled", 0, m_tvalid);
            expect_equal("s_tready while disabled", 0, s_tready);
        end
        axil_write(`REG_DECIM, d_readback);
        axil_read(`REG_DECIM, rd);
        expect_equal("DECIM readback", d_readback, rd);
        finish_test();

        // Strobe spacing and output latency
        start_test("strobe_period");
        @(posedge a_clk);
        m_tready <= 1'b1;
        strobe_at.delete();
        rise_at.delete();
        record_timing = 1'b1;
        axil_write(`REG_DECIM, d_period);
        axil_write(`REG_CTRL, 32'h1);
        n = 0;
        do
        begin
            @(negedge a_clk);
            n++;
        end
        while (rise_at.size() < 8 && n < STREAM_LIMIT);
        confirm_done(rise_at.size() >= 8, "eight m_tvalid pulses");
        record_timing = 1'b0;
        for (i = 0; i < 7 && i + 1 < rise_at.size() && i + 1 < strobe_at.size(); i++)
        begin
            expect_equal("strobe spacing", d_period + 1, strobe_at[i+1] - strobe_at[i]);
            expect_equal("strobe to m_tvalid", LATENCY, rise_at[i] - strobe_at[i]);
        end
        stop_and_drain();
        finish_test();

        // 200 samples from a zeroed window, monitor checks each beat
        start_test("moving_average");
        axil_write(`REG_DECIM, d_avg);
        stop_and_drain();
        clear_model();
        acc0 = accepted;
        del0 = delivered;
        axil_write(`REG_CTRL, 32'h3);
        wait_accepted(acc0 + 200);
        stop_and_drain();
        expect_equal("beats out", accepted - acc0, delivered - del0);
        finish_test();

        // Window holds data from the previous test here
        start_test("flush");
        axil_write(`REG_CTRL, 32'h1);
        wait_accepted(accepted + 20);
        stop_and_drain();
        clear_model();
        acc0 = accepted;
        del0 = delivered;
        axil_write(`REG_CTRL, 32'h3);
        wait_accepted(acc0 + 1);
        first = last_sample;
        await_beats(del0 + 1);
        expect_equal("first beat after flush", first >>> `TAPS_LOG2, last_out);
        wait_accepted(accepted + 40);
        stop_and_drain();
        finish_test();

        // Stalled output, N beats in
        start_test("overrun");
        axil_write(`REG_DECIM, d_overrun);
        @(posedge a_clk);
        m_tready <= 1'b0;
        acc0 = accepted;
        axil_write(`REG_CTRL, 32'h1);
        wait_accepted(acc0 + n_target);
        axil_write(`REG_CTRL, 32'h0);
        // Last accepted sample reaches the output register
        repeat (LATENCY + 1) @(negedge a_clk);
        n_beats = accepted - acc0;
        newest  = (exp_q.size() > 0) ? exp_q[$] : '0;
        expect_equal("m_tvalid held", 1, m_tvalid);
        expect_equal("m_tdata newest", newest, m_tdata);
        axil_read(`REG_STATUS, rd);
        expect_equal("overrun count", n_beats - 1, rd);
        axil_read(`REG_LAST, rd);
        expect_equal("LAST", {{(32-`SAMPLE_W){newest[`SAMPLE_W-1]}}, newest}, rd);
        axil_write(`REG_STATUS, 32'h0);
        axil_read(`REG_STATUS, rd);
        expect_equal("overrun count cleared", 32'h0, rd);
        axil_read(`REG_LAST, rd);
        expect_equal("LAST after clear", {{(32-`SAMPLE_W){newest[`SAMPLE_W-1]}}, newest}, rd);
        // Only the held beat is still to come out
        exp_q.delete();
        exp_q.push_back(newest);
        @(posedge a_clk);
        m_tready <= 1'b1;
        drain_results();
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
logic/boxcar_pkg.sv
logic/rate_strobe_gen.sv
logic/boxcar_accumulator.sv
logic/result_port.sv
logic/boxcar_regs.sv
logic/boxcar_top.sv
tests/boxcar_tb.sv
